/* flist.f */
+incdir+verification
src/rv_pkg.sv
src/reg_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/rv_core.sv
verification/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test completed successfully

SOURCES := $(FLIST) $(wildcard src/*.sv verification/*.sv verification/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BIN): $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verification/rv_ref_model.svh */
// include inside a module that imports rv_pkg; models only the rv32i subset the core decodes
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// architectural state, advanced once per retired instruction
logic [PC_WIDTH-1:0] ref_pc = '0;
logic [XLEN-1:0]     ref_regs [32] = '{default: '0};
logic [7:0]          ref_mem [1024];        // byte addressed, wraps at 1 KiB

function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                             input logic [XLEN-1:0] a,
                                             input logic [XLEN-1:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic void rv_step(input  logic [XLEN-1:0] instr_word,
                                output logic            rd_we,
                                output logic [4:0]      rd_addr,
                                output logic [XLEN-1:0] rd_data,
                                output logic            mem_we,
                                output logic [XLEN-1:0] mem_addr,
                                output logic [3:0]      mem_be,
                                output logic [XLEN-1:0] mem_data);
    instr_u              u;
    logic [XLEN-1:0]     a;
    logic [XLEN-1:0]     b;
    logic [XLEN-1:0]     imm_i;
    logic [XLEN-1:0]     imm_b;
    logic [XLEN-1:0]     imm_j;
    logic [XLEN-1:0]     addr;
    logic [XLEN-1:0]     res;
    logic [XLEN-1:0]     word_rd;
    logic [XLEN-1:0]     shifted;
    logic                writes;
    logic                taken;
    logic [PC_WIDTH-1:0] next_pc;
    u       = instr_word;
    a       = ref_regs[u.r.rs1];
    b       = ref_regs[u.r.rs2];
    imm_i   = 32'($signed(instr_word) >>> 20);
    imm_b   = {{20{instr_word[31]}}, instr_word[7], instr_word[30:25], instr_word[11:8], 1'b0};
    imm_j   = {{12{instr_word[31]}}, instr_word[19:12], instr_word[20], instr_word[30:21], 1'b0};
    addr    = a + imm_i;
    next_pc = ref_pc + 16'd4;
    writes  = 1'b1;
    res     = '0;
    mem_we  = 1'b0;
    mem_be  = 4'd0;
    mem_data = '0;
    case (opcode_t'(u.r.opcode))
        OPC_LUI:   res = {instr_word[31:12], 12'b0};
        OPC_AUIPC: res = 32'(ref_pc) + {instr_word[31:12], 12'b0};
        OPC_JAL: begin
            res     = 32'(next_pc);     // link
            next_pc = ref_pc + imm_j[PC_WIDTH-1:0];
        end
        OPC_JALR: begin
            res     = 32'(next_pc);
            next_pc = {addr[PC_WIDTH-1:1], 1'b0};
        end
        OPC_BRANCH: begin
            writes = 1'b0;
            case (u.r.funct3)
                3'd0:    taken = a == b;
                3'd1:    taken = a != b;
                3'd4:    taken = $signed(a) < $signed(b);
                3'd5:    taken = $signed(a) >= $signed(b);
                3'd6:    taken = a < b;
                default: taken = a >= b;
            endcase
            if (taken) next_pc = ref_pc + imm_b[PC_WIDTH-1:0];
        end
        OPC_LOAD: begin
            for (int lane = 0; lane < 4; lane++) begin
                word_rd[8*lane +: 8] = ref_mem[{addr[9:2], 2'(lane)}];
            end
            shifted = word_rd >> {addr[1:0], 3'b000};
            case (u.r.funct3)
                3'd0:    res = 32'($signed(shifted[7:0]));
                3'd1:    res = 32'($signed(shifted[15:0]));
                3'd4:    res = 32'(shifted[7:0]);
                3'd5:    res = 32'(shifted[15:0]);
                default: res = word_rd;
            endcase
        end
        OPC_STORE: begin
            writes   = 1'b0;
            mem_we   = 1'b1;
            mem_addr = a + {imm_i[31:5], instr_word[11:7]};
            mem_data = b << {mem_addr[1:0], 3'b000};
            case (u.r.funct3[1:0])
                2'd0:    mem_be = 4'b0001 << mem_addr[1:0];
                2'd1:    mem_be = 4'b0011 << mem_addr[1:0];
                default: mem_be = 4'b1111;
            endcase
            for (int lane = 0; lane < 4; lane++) begin
                if (mem_be[lane]) ref_mem[{mem_addr[9:2], 2'(lane)}] = mem_data[8*lane +: 8];
            end
        end
        OPC_OP_IMM: res = alu_ref(u.r.funct3, (u.r.funct3 == 3'd5) && instr_word[30], a, imm_i);
        OPC_OP:     res = alu_ref(u.r.funct3, instr_word[30], a, b);
        default:    writes = 1'b0;
    endcase
    rd_we   = writes && (u.r.rd != 5'd0);
    rd_addr = u.r.rd;
    rd_data = res;
    if (rd_we) ref_regs[u.r.rd] = res;
    ref_pc = next_pc;
endfunction

`endif

/* verification/rv_core_tb.sv */
// program footprint limited to 4 KiB of rom and a 64-byte data window written before any load
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int N_INSTR      = 600;
    localparam int PRELUDE_LEN  = 47;          // 31 addi then 16 sw
    localparam int SAMPLE_DELAY = 15;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + N_INSTR + 20) * CLK_PERIOD;

    logic                clk_i;
    logic                rst_n_i;
    logic [XLEN-1:0]     imem_data_i;
    logic [PC_WIDTH-1:0] imem_addr_o;
    logic                rd_we_o;
    logic [4:0]          rd_addr_o;
    logic [XLEN-1:0]     rd_data_o;
    logic                dmem_we_o;
    logic [XLEN-1:0]     dmem_addr_o;
    logic [XLEN-1:0]     dmem_wdata_o;
    logic [3:0]          dmem_be_o;

    logic [XLEN-1:0] rom [1024];
    integer          seed = 42;
    int              pc_errors = 0;
    int              reg_errors = 0;
    int              mem_errors = 0;

    `include "rv_ref_model.svh"

    rv_core i_rv_core (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .imem_data_i  (imem_data_i),
        .imem_addr_o  (imem_addr_o),
        .rd_we_o      (rd_we_o),
        .rd_addr_o    (rd_addr_o),
        .rd_data_o    (rd_data_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_be_o    (dmem_be_o)
    );

    // size-aligned offset inside the initialised data window
    function automatic logic [11:0] data_offset(input logic [1:0] size, input logic [5:0] bits);
        case (size)
            2'b10:   return {6'd0, bits[5:2], 2'b00};
            2'b01:   return {6'd0, bits[5:1], 1'b0};
            default: return {6'd0, bits};
        endcase
    endfunction

    // bits of r line up with rs2, rs1, funct3 and rd
    function automatic logic [XLEN-1:0] random_instr();
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        r   = $random(seed);
        s   = $random(seed);
        f3  = r[14:12];
        imm = r[31:20];
        case (s[3:0])
            4'd0, 4'd1: return {(f3 == 3'd0 || f3 == 3'd5) ? {1'b0, s[4], 5'd0} : 7'd0,
                                r[24:7], 7'b0110011};
            4'd2: return {r[31:7], 7'b0110111};
            4'd3: return {r[31:7], 7'b0010111};
            4'd4, 4'd5: begin
                if (f3[2:1] == 2'b01) f3 = {1'b1, f3[0], 1'b0}; // no funct3 2 or 3
                boff = {8'd0, s[7:5], 2'b00} + 13'd4;
                return {boff[12], boff[10:5], r[24:15], f3, boff[4:1], boff[11], 7'b1100011};
            end
            4'd6: begin
                joff = {15'd0, s[8:5], 2'b00} + 21'd4;
                return {joff[20], joff[10:1], joff[11], joff[19:12], r[11:7], 7'b1101111};
            end
            4'd7: return {1'b0, s[12:4], 2'b00, 8'd0, r[11:7], 7'b1100111}; // absolute target
            4'd8, 4'd9, 4'd10: begin
                if (f3 == 3'd3 || f3 >= 3'd6) f3 = f3 - 3'd2;
                return {data_offset(f3[1:0], s[9:4]), 5'd0, f3, r[11:7], 7'b0000011};
            end
            4'd11, 4'd12, 4'd13: begin
                f3  = {1'b0, (r[13:12] == 2'b11) ? 2'b10 : r[13:12]};
                imm = data_offset(f3[1:0], s[9:4]);
                return {imm[11:5], r[24:20], 5'd0, f3, imm[4:0], 7'b0100011};
            end
            default: begin
                if (f3 == 3'd1) imm = {7'd0, imm[4:0]};
                if (f3 == 3'd5) imm = {1'b0, s[4], 5'd0, imm[4:0]};
                return {imm, r[19:7], 7'b0010011};
            end
        endcase
    endfunction

    task automatic check_pc(input logic [PC_WIDTH-1:0] exp_pc, input logic [PC_WIDTH-1:0] act_pc);
        if (act_pc !== exp_pc) begin
            $display("Error: imem_addr_o expected %h, got %h", exp_pc, act_pc);
            pc_errors++;
        end
    endtask

    task automatic check_reg_write(input logic exp_we, input logic [4:0] exp_addr,
                                   input logic [XLEN-1:0] exp_data, input logic act_we,
                                   input logic [4:0] act_addr, input logic [XLEN-1:0] act_data);
        if (act_we !== exp_we) begin
            $display("Error: rd_we_o expected %h, got %h", exp_we, act_we);
            reg_errors++;
        end else if (exp_we && (act_addr !== exp_addr || act_data !== exp_data)) begin
            $display("Error: rd_addr_o/rd_data_o expected %h/%h, got %h/%h",
                     exp_addr, exp_data, act_addr, act_data);
            reg_errors++;
        end
    endtask

    task automatic check_mem_write(input logic exp_we, input logic [XLEN-1:0] exp_addr,
                                   input logic [3:0] exp_be, input logic [XLEN-1:0] exp_data,
                                   input logic act_we, input logic [XLEN-1:0] act_addr,
                                   input logic [3:0] act_be, input logic [XLEN-1:0] act_data);
        logic [XLEN-1:0] mask;
        for (int lane = 0; lane < 4; lane++) mask[8*lane +: 8] = {8{exp_be[lane]}};
        if (act_we !== exp_we) begin
            $display("Error: dmem_we_o expected %h, got %h", exp_we, act_we);
            mem_errors++;
        end else if (exp_we && (act_addr !== exp_addr || act_be !== exp_be)) begin
            $display("Error: dmem_addr_o/dmem_be_o expected %h/%h, got %h/%h",
                     exp_addr, exp_be, act_addr, act_be);
            mem_errors++;
        end else if (exp_we && (act_data & mask) !== (exp_data & mask)) begin
            $display("Error: dmem_wdata_o expected %h, got %h", exp_data & mask, act_data & mask);
            mem_errors++;
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        logic [11:0] off;
        rst_n_i     = 1'b0;
        imem_data_i = NOP_INSTR;
        for (int k = 1; k < 32; k++) begin
            rom[k-1] = {12'($random(seed)), 5'd0, 3'b000, 5'(k), 7'b0010011};
        end
        for (int k = 0; k < 16; k++) begin      // seed the data window from x1..x16
            off        = 12'(4 * k);
            rom[31+k] = {off[11:5], 5'(k + 1), 5'd0, 3'b010, off[4:0], 7'b0100011};
        end
        for (int k = PRELUDE_LEN; k < 1024; k++) rom[k] = random_instr();
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;
        forever begin
            imem_data_i = rom[imem_addr_o[11:2]];
            @(negedge clk_i);
        end
    end

    initial begin
        logic            e_rd_we;
        logic [4:0]      e_rd_addr;
        logic [XLEN-1:0] e_rd_data;
        logic            e_mem_we;
        logic [XLEN-1:0] e_mem_addr;
        logic [3:0]      e_mem_be;
        logic [XLEN-1:0] e_mem_data;
        int              steps;
        steps = 0;
        while (steps < N_INSTR) begin
            @(negedge clk_i);
            #SAMPLE_DELAY;
            if (!rst_n_i) begin
                check_pc('0, imem_addr_o);
                check_reg_write(1'b0, 5'd0, '0, rd_we_o, rd_addr_o, rd_data_o);
                check_mem_write(1'b0, '0, 4'd0, '0, dmem_we_o, dmem_addr_o, dmem_be_o,
                                dmem_wdata_o);
            end else begin
                check_pc(ref_pc, imem_addr_o);
                rv_step(rom[ref_pc[11:2]], e_rd_we, e_rd_addr, e_rd_data, e_mem_we,
                        e_mem_addr, e_mem_be, e_mem_data);
                check_reg_write(e_rd_we, e_rd_addr, e_rd_data, rd_we_o, rd_addr_o, rd_data_o);
                check_mem_write(e_mem_we, e_mem_addr, e_mem_be, e_mem_data, dmem_we_o,
                                dmem_addr_o, dmem_be_o, dmem_wdata_o);
                steps++;
            end
        end
        $display("errors: pc %0d, register write %0d, memory write %0d",
                 pc_errors, reg_errors, mem_errors);
        if (pc_errors + reg_errors + mem_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #WATCHDOG_NS;
        $display("run timed out before all instructions were compared");
        $display("Test failed");
        $finish;
    end

endmodule

/* src/rv_core.sv */
// single-cycle rv32i core; instruction memory is external and must answer combinationally
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [XLEN-1:0]     imem_data_i,
    output logic [PC_WIDTH-1:0] imem_addr_o,
    output logic                rd_we_o,
    output logic [4:0]          rd_addr_o,
    output logic [XLEN-1:0]     rd_data_o,
    output logic                dmem_we_o,
    output logic [XLEN-1:0]     dmem_addr_o,
    output logic [XLEN-1:0]     dmem_wdata_o,
    output logic [3:0]          dmem_be_o
);

    logic [PC_WIDTH-1:0] pc;
    logic [XLEN-1:0]     rs1_data;
    logic [XLEN-1:0]     rs2_data;
    logic [XLEN-1:0]     imm;
    alu_op_t             alu_op;
    src_a_t              src_a;
    src_b_t              src_b;
    logic [2:0]          funct3;
    logic                is_branch;
    logic                is_jump;
    logic                mem_read;
    logic                mem_write;
    wb_sel_t             wb_sel;
    logic [XLEN-1:0]     alu_result;
    logic                take_jump;
    logic [PC_WIDTH-1:0] jump_target;
    logic [XLEN-1:0]     store_data;
    logic [XLEN-1:0]     wb_data;

    assign imem_addr_o = pc;
    assign dmem_addr_o = alu_result;
    assign rd_data_o   = wb_data;

    fetch_stage i_fetch_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .take_jump_i   (take_jump),
        .jump_target_i (jump_target),
        .pc_o          (pc)
    );

    decode_stage i_decode_stage (
        .clk_i       (clk_i),
        .instr_i     (imem_data_i),
        .pc_i        (pc),
        .wb_data_i   (wb_data),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .imm_o       (imm),
        .alu_op_o    (alu_op),
        .src_a_o     (src_a),
        .src_b_o     (src_b),
        .funct3_o    (funct3),
        .is_branch_o (is_branch),
        .is_jump_o   (is_jump),
        .mem_read_o  (mem_read),
        .mem_write_o (mem_write),
        .wb_sel_o    (wb_sel),
        .rd_we_o     (rd_we_o),
        .rd_addr_o   (rd_addr_o)
    );

    execute_stage i_execute_stage (
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .imm_i         (imm),
        .alu_op_i      (alu_op),
        .src_a_i       (src_a),
        .src_b_i       (src_b),
        .funct3_i      (funct3),
        .is_branch_i   (is_branch),
        .is_jump_i     (is_jump),
        .alu_result_o  (alu_result),
        .take_jump_o   (take_jump),
        .jump_target_o (jump_target),
        .store_data_o  (store_data)
    );

    memory_stage i_memory_stage (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .alu_result_i (alu_result),
        .store_data_i (store_data),
        .funct3_i     (funct3),
        .mem_read_i   (mem_read),
        .mem_write_i  (mem_write),
        .wb_sel_i     (wb_sel),
        .pc_i         (pc),
        .wb_data_o    (wb_data),
        .dmem_we_o    (dmem_we_o),
        .dmem_be_o    (dmem_be_o),
        .dmem_wdata_o (dmem_wdata_o)
    );

endmodule

/* src/memory_stage.sv */
// 1 KiB data memory, upper address bits ignored; misaligned accesses are not handled
`timescale 1ns/1ps

module memory_stage import rv_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [XLEN-1:0]     alu_result_i,
    input  logic [XLEN-1:0]     store_data_i,
    input  logic [2:0]          funct3_i,
    input  logic                mem_read_i,
    input  logic                mem_write_i,
    input  wb_sel_t             wb_sel_i,
    input  logic [PC_WIDTH-1:0] pc_i,
    output logic [XLEN-1:0]     wb_data_o,
    output logic                dmem_we_o,
    output logic [3:0]          dmem_be_o,
    output logic [XLEN-1:0]     dmem_wdata_o
);

    logic [3:0][7:0] mem [DMEM_WORDS];     // four byte lanes per word

    logic [$clog2(DMEM_WORDS)-1:0] word_addr;
    logic [1:0]                    byte_off;
    logic [XLEN-1:0]               rd_word;
    logic [XLEN-1:0]               rd_shifted;
    logic [XLEN-1:0]               load_val;
    logic [PC_WIDTH-1:0]           pc_plus4;

    assign word_addr = alu_result_i[$clog2(DMEM_WORDS)+1:2];
    assign byte_off  = alu_result_i[1:0];
    assign dmem_we_o = mem_write_i;

    // replicate store data across lanes, enables pick the lane
    always_comb begin
        case (funct3_i[1:0])
            2'b00: begin
                dmem_wdata_o = {4{store_data_i[7:0]}};
                dmem_be_o    = 4'b0001 << byte_off;
            end
            2'b01: begin
                dmem_wdata_o = {2{store_data_i[15:0]}};
                dmem_be_o    = 4'b0011 << byte_off;
            end
            default: begin
                dmem_wdata_o = store_data_i;
                dmem_be_o    = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (mem_write_i) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dmem_be_o[lane]) begin
                    mem[word_addr][lane] <= dmem_wdata_o[8*lane +: 8];
                end
            end
        end
    end

    assign rd_word    = mem[word_addr];     // asynchronous read
    assign rd_shifted = rd_word >> {byte_off, 3'b000};

    always_comb begin
        case (funct3_i)
            3'b000:  load_val = {{24{rd_shifted[7]}}, rd_shifted[7:0]};    // lb
            3'b001:  load_val = {{16{rd_shifted[15]}}, rd_shifted[15:0]};  // lh
            3'b100:  load_val = {24'b0, rd_shifted[7:0]};                  // lbu
            3'b101:  load_val = {16'b0, rd_shifted[15:0]};                 // lhu
            default: load_val = rd_word;                                   // lw
        endcase
    end

    assign pc_plus4 = pc_i + PC_WIDTH'(4);

    always_comb begin
        case (wb_sel_i)
            WB_LOAD:     wb_data_o = load_val;
            WB_PC_PLUS4: wb_data_o = {{(XLEN-PC_WIDTH){1'b0}}, pc_plus4};
            default:     wb_data_o = alu_result_i;
        endcase
    end

    // size from decode, address from execute
    a_aligned_access : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (mem_read_i || mem_write_i) |->
            (funct3_i[1:0] == 2'b00) ||
            (funct3_i[1:0] == 2'b01 && !byte_off[0]) ||
            (byte_off == 2'b00)
    ) else $error("misaligned access at %0h, funct3 %0b", alu_result_i, funct3_i);

endmodule

/* src/execute_stage.sv */
// purely combinational; jump target is truncated to PC_WIDTH bits
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
    input  logic [PC_WIDTH-1:0] pc_i,
    input  logic [XLEN-1:0]     rs1_data_i,
    input  logic [XLEN-1:0]     rs2_data_i,
    input  logic [XLEN-1:0]     imm_i,
    input  alu_op_t             alu_op_i,
    input  src_a_t              src_a_i,
    input  src_b_t              src_b_i,
    input  logic [2:0]          funct3_i,
    input  logic                is_branch_i,
    input  logic                is_jump_i,
    output logic [XLEN-1:0]     alu_result_o,
    output logic                take_jump_o,
    output logic [PC_WIDTH-1:0] jump_target_o,
    output logic [XLEN-1:0]     store_data_o
);

    logic [XLEN-1:0]     op_a;
    logic [XLEN-1:0]     op_b;
    logic [4:0]          shamt;
    logic                branch_taken;
    logic [PC_WIDTH-1:0] branch_target;

    always_comb begin
        case (src_a_i)
            SRC_A_RS1:  op_a = rs1_data_i;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = {{(XLEN-PC_WIDTH){1'b0}}, pc_i};
        endcase
    end

    assign op_b  = (src_b_i == SRC_B_IMM) ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_result_o = op_a - op_b;
            ALU_SLL:    alu_result_o = op_a << shamt;
            ALU_SLT:    alu_result_o = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result_o = {31'b0, op_a < op_b};
            ALU_XOR:    alu_result_o = op_a ^ op_b;
            ALU_SRL:    alu_result_o = op_a >> shamt;
            ALU_SRA:    alu_result_o = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_result_o = op_a | op_b;
            ALU_AND:    alu_result_o = op_a & op_b;
            ALU_PASS_B: alu_result_o = op_b;
            default:    alu_result_o = op_a + op_b; // add, address and link math
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (funct3_i)
            3'b000:  branch_taken = rs1_data_i == rs2_data_i;
            3'b001:  branch_taken = rs1_data_i != rs2_data_i;
            3'b100:  branch_taken = $signed(rs1_data_i) < $signed(rs2_data_i);
            3'b101:  branch_taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
            3'b110:  branch_taken = rs1_data_i < rs2_data_i;
            3'b111:  branch_taken = rs1_data_i >= rs2_data_i;
            default: branch_taken = 1'b0;
        endcase
    end

    assign branch_target = pc_i + imm_i[PC_WIDTH-1:0];
    assign take_jump_o   = is_jump_i || (is_branch_i && branch_taken);

    // jal and jalr both come out of the alu, bit 0 cleared
    assign jump_target_o = is_branch_i ? branch_target
                                       : {alu_result_o[PC_WIDTH-1:1], 1'b0};

    assign store_data_o = rs2_data_i;       // lane shifting happens in memory

endmodule

/* src/decode_stage.sv */
// unsupported opcodes decode as no-ops and are flagged only by assertion
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
    input  logic                clk_i,
    input  logic [XLEN-1:0]     instr_i,
    input  logic [PC_WIDTH-1:0] pc_i,
    input  logic [XLEN-1:0]     wb_data_i,
    output logic [XLEN-1:0]     rs1_data_o,
    output logic [XLEN-1:0]     rs2_data_o,
    output logic [XLEN-1:0]     imm_o,
    output alu_op_t             alu_op_o,
    output src_a_t              src_a_o,
    output src_b_t              src_b_o,
    output logic [2:0]          funct3_o,
    output logic                is_branch_o,
    output logic                is_jump_o,
    output logic                mem_read_o,
    output logic                mem_write_o,
    output wb_sel_t             wb_sel_o,
    output logic                rd_we_o,
    output logic [4:0]          rd_addr_o
);

    instr_u     instr;
    opcode_t    opcode;
    logic [6:0] funct7;
    logic       writes_rd;

    function automatic alu_op_t alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign instr     = instr_i;
    assign opcode    = opcode_t'(instr.r.opcode);
    assign funct7    = instr.r.funct7;
    assign funct3_o  = instr.r.funct3;
    assign rd_addr_o = instr.r.rd;
    assign rd_we_o   = writes_rd && (instr.r.rd != 5'd0);

    // sign-extended immediate per format
    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: imm_o = {instr.u.imm31_12, 12'b0};
            OPC_JAL: imm_o = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11,
                              instr.j.imm10_1, 1'b0};
            OPC_BRANCH: imm_o = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                                 instr.b.imm4_1, 1'b0};
            OPC_STORE: imm_o = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
            default: imm_o = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0}; // I-type
        endcase
    end

    always_comb begin
        alu_op_o    = ALU_ADD;
        src_a_o     = SRC_A_RS1;
        src_b_o     = SRC_B_IMM;
        is_branch_o = 1'b0;
        is_jump_o   = 1'b0;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        wb_sel_o    = WB_ALU;
        writes_rd   = 1'b0;
        case (opcode)
            OPC_LUI: begin
                src_a_o   = SRC_A_ZERO;
                alu_op_o  = ALU_PASS_B;
                writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                src_a_o   = SRC_A_PC;
                writes_rd = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                src_a_o   = (opcode == OPC_JAL) ? SRC_A_PC : SRC_A_RS1;
                is_jump_o = 1'b1;
                wb_sel_o  = WB_PC_PLUS4;
                writes_rd = 1'b1;
            end
            OPC_BRANCH: begin
                src_b_o     = SRC_B_RS2;  // comparator reads rs1/rs2 directly
                is_branch_o = 1'b1;
            end
            OPC_LOAD: begin
                mem_read_o = 1'b1;
                wb_sel_o   = WB_LOAD;
                writes_rd  = 1'b1;
            end
            OPC_STORE: mem_write_o = 1'b1;
            OPC_OP_IMM: begin
                // funct7 only matters for srai
                alu_op_o  = alu_from_funct(instr.i.funct3,
                                           funct7[5] && (instr.i.funct3 == 3'b101));
                writes_rd = 1'b1;
            end
            OPC_OP: begin
                src_b_o   = SRC_B_RS2;
                alu_op_o  = alu_from_funct(instr.r.funct3, funct7[5]);
                writes_rd = 1'b1;
            end
            default: ;
        endcase
    end

    reg_file i_reg_file (
        .clk_i (clk_i),
        .ra1_i (instr.r.rs1),
        .ra2_i (instr.r.rs2),
        .wa_i  (instr.r.rd),
        .we_i  (rd_we_o),
        .wd_i  (wb_data_i),
        .rd1_o (rs1_data_o),
        .rd2_o (rs2_data_o)
    );

    // instruction word is undriven before the first fetch
    a_known_opcode : assert property (
        @(posedge clk_i) disable iff ($isunknown(instr_i))
        opcode inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                       OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP}
    ) else $error("unsupported opcode %0h at pc %0h", instr.r.opcode, pc_i);

endmodule

/* src/fetch_stage.sv */
// pc resets to zero; jump targets must be word aligned, no misaligned-fetch trap exists
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                take_jump_i,
    input  logic [PC_WIDTH-1:0] jump_target_i,
    output logic [PC_WIDTH-1:0] pc_o
);

    logic [PC_WIDTH-1:0] pc_q;
    logic [PC_WIDTH-1:0] pc_next;

    assign pc_next = take_jump_i ? jump_target_i : pc_q + PC_WIDTH'(4);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // a jalr with bit 1 set in rs1+imm would land here
    a_pc_aligned : assert property (
        @(posedge clk_i) disable iff (!rst_n_i) pc_q[1:0] == 2'b00
    ) else $error("pc %0h not word aligned", pc_q);

endmodule

/* src/reg_file.sv */
// no reset on contents; x0 reads zero, caller must never raise we_i for x0
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic            clk_i,
    input  logic [4:0]      ra1_i,
    input  logic [4:0]      ra2_i,
    input  logic [4:0]      wa_i,
    input  logic            we_i,
    input  logic [XLEN-1:0] wd_i,
    output logic [XLEN-1:0] rd1_o,
    output logic [XLEN-1:0] rd2_o
);

    logic [XLEN-1:0] regs [32];

    // entry 0 is never written, so mask it on read
    assign rd1_o = (ra1_i == 5'd0) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == 5'd0) ? '0 : regs[ra2_i];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            regs[wa_i] <= wd_i;
        end
    end

endmodule

/* src/rv_pkg.sv */
// rv32i subset only; no FENCE, CSR, ECALL/EBREAK or M extension encodings are defined here
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int PC_WIDTH   = 16;           // upper bits of PC-derived words read as zero
    localparam int DMEM_WORDS = 256;          // word index from byte address bits 9:2
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    // major opcodes the core executes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASS_B                            // lui
    } alu_op_t;

    typedef enum logic [1:0] {SRC_A_RS1, SRC_A_ZERO, SRC_A_PC} src_a_t;

    typedef enum logic {SRC_B_RS2, SRC_B_IMM} src_b_t;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC_PLUS4} wb_sel_t;

    // one instruction word, six views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

endpackage
